// ==== src.f ====
logic/isa_pkg.sv
logic/issue_pkg.sv
logic/issue_queue.sv
logic/pair_check.sv
logic/operand_read.sv
logic/regfile.sv
logic/issue_stage.sv
tb/issue_assertions.sv
tb/issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Done: errors found

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@status=0; $(SIM_BIN) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/issue_tb.sv ====
module issue_tb;

    localparam int DEPTH          = issue_pkg::DEFAULT_DEPTH;
    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int N_INSTR        = 300;
    localparam int FLUSH_FROM     = 220;
    localparam int TIMEOUT_CYCLES = 8 * N_INSTR + 200;

    logic                         clk;
    logic                         reset;
    logic                         flush;
    isa_pkg::instr_t [1:0]        in;
    logic [1:0]                   in_valid;
    logic                         in_ready;
    issue_pkg::issue_slot_t [1:0] out;
    logic [1:0]                   out_valid;
    logic                         out_ready;
    issue_pkg::wb_t [1:0]         wb;

    isa_pkg::word_t  model_regs [32];
    isa_pkg::instr_t model_q [$];

    int             seed;
    int             cycles = 0;
    int             n_accepted;
    isa_pkg::word_t next_pc;
    logic           last_bj;

    // what the previous observation saw
    issue_pkg::issue_slot_t [1:0] prev_out;
    logic [1:0]                   prev_valid;
    logic                         prev_ready;
    logic                         prev_flush;

    issue_stage #(
        .DEPTH(DEPTH)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .in       (in),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out      (out),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .wb       (wb)
    );

    bind issue_stage issue_assertions chk0 (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .in_ready (in_ready),
        .out      (out),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_slot(input string name, input issue_pkg::issue_slot_t got,
                              input issue_pkg::issue_slot_t exp);
        if (got !== exp)
            fail_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_valid(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
    endtask

    // bits: regwrite mem bj muldiv reads_a reads_b
    function automatic isa_pkg::ctl_t expected_ctl(input isa_pkg::op_t op);
        isa_pkg::ctl_t c;
        case (op)
            isa_pkg::OP_ALU:    c = 6'b100011;
            isa_pkg::OP_LOAD:   c = 6'b110010;
            isa_pkg::OP_STORE:  c = 6'b010011;
            isa_pkg::OP_BRANCH: c = 6'b001011;
            isa_pkg::OP_JUMP:   c = 6'b001000;
            isa_pkg::OP_MULDIV: c = 6'b100111;
            default:            c = 6'b000000;
        endcase
        return c;
    endfunction

    function automatic issue_pkg::issue_slot_t expected_slot(input isa_pkg::instr_t i);
        issue_pkg::issue_slot_t s;
        isa_pkg::ctl_t          c;
        c       = expected_ctl(i.op);
        s.instr = i;
        s.opa   = c.reads_a ? model_regs[i.src_a] : '0;
        s.opb   = c.reads_b ? model_regs[i.src_b] : '0;
        return s;
    endfunction

    function automatic logic pair_allowed(input isa_pkg::instr_t old_i,
                                          input isa_pkg::instr_t young_i);
        isa_pkg::ctl_t co;
        isa_pkg::ctl_t cy;
        logic          raw;
        co  = expected_ctl(old_i.op);
        cy  = expected_ctl(young_i.op);
        raw = co.regwrite && (old_i.dest != 5'd0) &&
              ((cy.reads_a && old_i.dest == young_i.src_a) ||
               (cy.reads_b && old_i.dest == young_i.src_b));
        return !cy.bj && !raw && !(co.mem && cy.mem) && !(co.muldiv && cy.muldiv);
    endfunction

    // a delay slot never holds another branch or jump
    function automatic isa_pkg::instr_t random_instr(input logic allow_bj,
                                                     input isa_pkg::word_t pc);
        isa_pkg::instr_t i;
        logic [31:0]     r;
        r    = $random(seed);
        i.pc = pc;
        i.op = isa_pkg::op_t'(3'(r % 32'd6));
        if (!allow_bj && i.op == isa_pkg::OP_BRANCH)
            i.op = isa_pkg::OP_ALU;
        if (!allow_bj && i.op == isa_pkg::OP_JUMP)
            i.op = isa_pkg::OP_LOAD;
        // registers 0..7 only, so RAW pairs come up often
        i.dest  = {2'b00, r[5:3]};
        i.src_a = {2'b00, r[8:6]};
        i.src_b = {2'b00, r[11:9]};
        i.imm   = r[31:16];
        return i;
    endfunction

    task automatic drive_stream(input logic allow_flush);
        logic [31:0]   r;
        isa_pkg::ctl_t c1;
        r     = $random(seed);
        in[1] = random_instr(!last_bj, next_pc);
        c1    = expected_ctl(in[1].op);
        in[0] = random_instr(!c1.bj, next_pc + 32'd4);
        case (r[1:0])
            2'd0:    in_valid = 2'b00;
            2'd1:    in_valid = 2'b10;
            default: in_valid = 2'b11;
        endcase
        out_ready = (r[3:2] != 2'b00);
        flush     = allow_flush && (r[8:4] == 5'd0);
    endtask

    task automatic accept(input isa_pkg::instr_t i);
        isa_pkg::ctl_t c;
        c = expected_ctl(i.op);
        model_q.push_back(i);
        next_pc    = next_pc + 32'd4;
        n_accepted = n_accepted + 1;
        last_bj    = c.bj;
    endtask

    // runs between edges, where every DUT output is settled
    task automatic observe_cycle();
        int                     occ;
        issue_pkg::issue_slot_t exp_old;
        issue_pkg::issue_slot_t exp_young;
        isa_pkg::ctl_t          c_old;
        if (out_valid == 2'b01)
            fail_run("out_valid shows slot 0 in use without slot 1");
        if (prev_flush)
            check_valid("out_valid after flush", out_valid, 2'b00);
        else if (prev_valid != 2'b00 && !prev_ready)
        begin
            check_valid("out_valid under stall", out_valid, prev_valid);
            check_slot("out[1] under stall", out[1], prev_out[1]);
            check_slot("out[0] under stall", out[0], prev_out[0]);
        end
        occ = model_q.size() - $countones(out_valid);
        check_flag("in_ready", in_ready, (DEPTH - occ) >= 2);
        if (out_valid != 2'b00 && out_ready && !flush)
        begin
            if (model_q.size() < $countones(out_valid))
                fail_run("output delivered an instruction that was never accepted");
            exp_old = expected_slot(model_q.pop_front());
            check_slot("out[1]", out[1], exp_old);
            c_old = expected_ctl(exp_old.instr.op);
            if (c_old.bj)
                check_valid("out_valid with branch in slot 1", out_valid, 2'b11);
            if (out_valid[0])
            begin
                exp_young = expected_slot(model_q.pop_front());
                check_slot("out[0]", out[0], exp_young);
                if (!pair_allowed(exp_old.instr, exp_young.instr))
                    fail_run($sformatf("pc %h and pc %h issued together against the pair rule",
                                       exp_old.instr.pc, exp_young.instr.pc));
            end
        end
        if (flush)
        begin
            model_q.delete();
            last_bj = 1'b0;
        end
        else if (in_ready)
        begin
            if (in_valid[1])
                accept(in[1]);
            if (in_valid[0])
                accept(in[0]);
        end
        prev_out   = out;
        prev_valid = out_valid;
        prev_ready = out_ready;
        prev_flush = flush;
    endtask

    task automatic stream_cycle(input logic allow_flush);
        @(posedge clk);
        #(DRIVE_DELAY);
        drive_stream(allow_flush);
        @(negedge clk);
        observe_cycle();
    endtask

    task automatic drain_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        in_valid  = 2'b00;
        flush     = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        observe_cycle();
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            fail_run($sformatf("run timed out after %0d cycles", cycles));
    end

    initial
    begin
        seed       = 32'h18d3_1dd2;
        reset      = 1'b0;
        flush      = 1'b0;
        in         = '0;
        in_valid   = 2'b00;
        out_ready  = 1'b0;
        wb         = '0;
        next_pc    = 32'h0000_1000;
        n_accepted = 0;
        last_bj    = 1'b0;
        prev_out   = '0;
        prev_valid = 2'b00;
        prev_ready = 1'b0;
        prev_flush = 1'b0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;

        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b1;
        @(negedge clk);
        check_valid("out_valid after reset", out_valid, 2'b00);
        check_flag("in_ready after reset", in_ready, 1'b1);

        // fill registers 1..31, two per cycle
        for (int k = 1; k < 32; k += 2)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            wb[1].en   = 1'b1;
            wb[1].addr = 5'(k);
            wb[1].data = $random(seed);
            wb[0].en   = (k + 1 < 32);
            wb[0].addr = 5'(k + 1);
            wb[0].data = $random(seed);
            model_regs[k] = wb[1].data;
            if (k + 1 < 32)
                model_regs[k + 1] = wb[0].data;
        end
        // register zero ignores writes on either port
        @(posedge clk);
        #(DRIVE_DELAY);
        wb[1].en   = 1'b1;
        wb[1].addr = 5'd0;
        wb[1].data = $random(seed);
        wb[0].en   = 1'b1;
        wb[0].addr = 5'd0;
        wb[0].data = $random(seed);
        @(posedge clk);
        #(DRIVE_DELAY);
        wb = '0;

        while (n_accepted < FLUSH_FROM)
            stream_cycle(1'b0);
        // rare flushes only near the end of the stream
        while (n_accepted < N_INSTR || last_bj)
            stream_cycle(1'b1);

        while (model_q.size() != 0)
            drain_cycle();
        drain_cycle();
        check_valid("out_valid after drain", out_valid, 2'b00);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== tb/issue_assertions.sv ====
module issue_assertions (
    input logic                         clk,
    input logic                         reset,
    input logic                         flush,
    input logic                         in_ready,
    input issue_pkg::issue_slot_t [1:0] out,
    input logic [1:0]                   out_valid,
    input logic                         out_ready
);

    // execute sees a steady pair while it stalls
    property hold_under_stall;
        @(posedge clk) disable iff (!reset)
            (out_valid != 2'b00 && !out_ready && !flush) |=> ($stable(out) && $stable(out_valid));
    endproperty

    assert property (hold_under_stall)
        else $error("output pair changed while execute stalled");

    // slot 1 always carries the older instruction
    assert property (@(posedge clk) disable iff (!reset) out_valid != 2'b01)
        else $error("out_valid shows only slot 0 in use");

    assert property (@(posedge clk) $rose(reset) |-> in_ready)
        else $error("in_ready low in the first cycle after reset");

endmodule

// ==== logic/issue_stage.sv ====
module issue_stage #(
    parameter int DEPTH = issue_pkg::DEFAULT_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  isa_pkg::instr_t [1:0]        in,
    input  logic [1:0]                   in_valid,
    output logic                         in_ready,
    output issue_pkg::issue_slot_t [1:0] out,
    output logic [1:0]                   out_valid,
    input  logic                         out_ready,
    input  issue_pkg::wb_t [1:0]         wb
);

    isa_pkg::instr_t head_old;
    isa_pkg::instr_t head_young;
    logic            old_valid;
    logic            young_valid;

    issue_pkg::pair_t pair;
    issue_pkg::pair_t pop;
    logic             advance;

    isa_pkg::reg_addr_t [3:0]     raddr;
    isa_pkg::word_t [3:0]         rdata;
    issue_pkg::issue_slot_t [1:0] slot;

    // the output pair moves on when execute takes it or it is empty
    assign advance = out_ready || (out_valid == 2'b00);

    assign pop.issue_old   = pair.issue_old && advance;
    assign pop.issue_young = pair.issue_young && advance;

    issue_queue #(
        .DEPTH(DEPTH)
    ) queue0 (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in         (in),
        .in_valid   (in_valid),
        .pop        (pop),
        .in_ready   (in_ready),
        .head_old   (head_old),
        .head_young (head_young),
        .old_valid  (old_valid),
        .young_valid(young_valid)
    );

    pair_check pair0 (
        .old_instr  (head_old),
        .young_instr(head_young),
        .old_valid  (old_valid),
        .young_valid(young_valid),
        .pair       (pair)
    );

    // ports 3..0 are older a, older b, younger a, younger b
    assign raddr = {head_old.src_a, head_old.src_b, head_young.src_a, head_young.src_b};

    regfile rf0 (
        .clk  (clk),
        .reset(reset),
        .raddr(raddr),
        .wb   (wb),
        .rdata(rdata)
    );

    operand_read read_old (
        .instr  (head_old),
        .rdata_a(rdata[3]),
        .rdata_b(rdata[2]),
        .slot   (slot[1])
    );

    operand_read read_young (
        .instr  (head_young),
        .rdata_a(rdata[1]),
        .rdata_b(rdata[0]),
        .slot   (slot[0])
    );

    always_ff @(posedge clk)
    begin
        if (!reset)
            out_valid <= 2'b00;
        else if (flush)
            out_valid <= 2'b00;
        else if (advance)
            out_valid <= {pair.issue_old, pair.issue_young};
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            out <= slot;
    end

endmodule

// ==== logic/regfile.sv ====
module regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::reg_addr_t [3:0] raddr,
    input  issue_pkg::wb_t [1:0]     wb,
    output isa_pkg::word_t [3:0]     rdata
);

    isa_pkg::word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else
        begin
            // register zero keeps its reset value, so it always reads zero
            if (wb[0].en && wb[0].addr != '0)
                regs[wb[0].addr] <= wb[0].data;
            // port 1 comes last so it wins on the same register
            if (wb[1].en && wb[1].addr != '0)
                regs[wb[1].addr] <= wb[1].data;
        end
    end

    // reads see the value before this cycle's write
    always_comb
    begin
        for (int r = 0; r < 4; r++)
            rdata[r] = regs[raddr[r]];
    end

endmodule

// ==== logic/operand_read.sv ====
module operand_read (
    input  isa_pkg::instr_t        instr,
    input  isa_pkg::word_t         rdata_a,
    input  isa_pkg::word_t         rdata_b,
    output issue_pkg::issue_slot_t slot
);

    isa_pkg::ctl_t ctl;

    assign ctl = isa_pkg::ctl_of(instr.op);

    assign slot.instr = instr;

    // unused sources go out as zero
    assign slot.opa = ctl.reads_a ? rdata_a : '0;
    assign slot.opb = ctl.reads_b ? rdata_b : '0;

endmodule

// ==== logic/pair_check.sv ====
module pair_check (
    input  isa_pkg::instr_t  old_instr,
    input  isa_pkg::instr_t  young_instr,
    input  logic             old_valid,
    input  logic             young_valid,
    output issue_pkg::pair_t pair
);

    isa_pkg::ctl_t old_ctl;
    isa_pkg::ctl_t young_ctl;

    logic raw_a;
    logic raw_b;
    logic raw;
    logic both_mem;
    logic both_muldiv;
    logic wait_slot;

    assign old_ctl   = isa_pkg::ctl_of(old_instr.op);
    assign young_ctl = isa_pkg::ctl_of(young_instr.op);

    // register zero never creates a dependency
    assign raw_a = young_ctl.reads_a && (old_instr.dest == young_instr.src_a);
    assign raw_b = young_ctl.reads_b && (old_instr.dest == young_instr.src_b);
    assign raw   = old_ctl.regwrite && (old_instr.dest != '0) && (raw_a || raw_b);

    assign both_mem    = old_ctl.mem && young_ctl.mem;
    assign both_muldiv = old_ctl.muldiv && young_ctl.muldiv;

    // a branch or jump holds until its delay slot has arrived
    assign wait_slot = old_ctl.bj && !young_valid;

    assign pair.issue_old   = old_valid && !wait_slot;
    assign pair.issue_young = pair.issue_old && young_valid && !young_ctl.bj &&
                              !raw && !both_mem && !both_muldiv;

endmodule

// ==== logic/issue_queue.sv ====
module issue_queue #(
    parameter int DEPTH = issue_pkg::DEFAULT_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  isa_pkg::instr_t [1:0] in,
    input  logic [1:0]            in_valid,
    input  issue_pkg::pair_t      pop,
    output logic                  in_ready,
    output isa_pkg::instr_t       head_old,
    output isa_pkg::instr_t       head_young,
    output logic                  old_valid,
    output logic                  young_valid
);

    localparam int PTR_W = $clog2(DEPTH);

    isa_pkg::instr_t  mem [DEPTH];
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] valid_next;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] head_plus1;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] tail_plus1;
    logic [PTR_W-1:0] tail_second;

    logic [1:0] push;
    logic [1:0] n_push;
    logic [1:0] n_pop;

    assign head_plus1 = head + PTR_W'(1);
    assign tail_plus1 = tail + PTR_W'(1);

    // entries stay contiguous, so two free slots at the tail means room for a pair
    assign in_ready = !valid[tail] && !valid[tail_plus1];

    assign push = in_valid & {2{in_ready}};

    // element 0 follows element 1, or takes the tail when it comes alone
    assign tail_second = push[1] ? tail_plus1 : tail;

    assign n_push = {1'b0, push[1]} + {1'b0, push[0]};
    assign n_pop  = {1'b0, pop.issue_old} + {1'b0, pop.issue_young};

    always_comb
    begin
        valid_next = valid;
        if (pop.issue_old)
            valid_next[head] = 1'b0;
        if (pop.issue_young)
            valid_next[head_plus1] = 1'b0;
        if (push[1])
            valid_next[tail] = 1'b1;
        if (push[0])
            valid_next[tail_second] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end
        else if (flush)
        begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end
        else
        begin
            valid <= valid_next;
            head  <= head + PTR_W'(n_pop);
            tail  <= tail + PTR_W'(n_push);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push[1] && !flush)
            mem[tail] <= in[1];
        if (push[0] && !flush)
            mem[tail_second] <= in[0];
    end

    assign head_old    = mem[head];
    assign head_young  = mem[head_plus1];
    assign old_valid   = valid[head];
    assign young_valid = valid[head_plus1];

endmodule

// ==== logic/issue_pkg.sv ====
package issue_pkg;

    // one slot handed to execute
    typedef struct packed {
        isa_pkg::instr_t instr;
        isa_pkg::word_t  opa;
        isa_pkg::word_t  opb;
    } issue_slot_t;

    // one write-back port into the register file
    typedef struct packed {
        logic               en;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t     data;
    } wb_t;

    // issue_young is only ever set together with issue_old
    typedef struct packed {
        logic issue_old;
        logic issue_young;
    } pair_t;

    localparam int DEFAULT_DEPTH = 8;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4,
        OP_MULDIV = 3'd5
    } op_t;

    typedef struct packed {
        logic regwrite;
        logic mem;
        logic bj;
        logic muldiv;
        logic reads_a;
        logic reads_b;
    } ctl_t;

    typedef struct packed {
        word_t       pc;
        op_t         op;
        reg_addr_t   dest;
        reg_addr_t   src_a;
        reg_addr_t   src_b;
        logic [15:0] imm;
    } instr_t;

    // fixed decode of the control bits, everything not listed stays low
    function automatic ctl_t ctl_of(op_t op);
        ctl_t c;
        c = '0;
        case (op)
            OP_ALU:    c = '{regwrite: 1'b1, reads_a: 1'b1, reads_b: 1'b1, default: 1'b0};
            OP_LOAD:   c = '{regwrite: 1'b1, mem: 1'b1, reads_a: 1'b1, default: 1'b0};
            OP_STORE:  c = '{mem: 1'b1, reads_a: 1'b1, reads_b: 1'b1, default: 1'b0};
            OP_BRANCH: c = '{bj: 1'b1, reads_a: 1'b1, reads_b: 1'b1, default: 1'b0};
            OP_JUMP:   c = '{bj: 1'b1, default: 1'b0};
            OP_MULDIV: c = '{regwrite: 1'b1, muldiv: 1'b1, reads_a: 1'b1, reads_b: 1'b1,
                             default: 1'b0};
            default:   c = '0;
        endcase
        return c;
    endfunction

endpackage
